/* rtl/carrierLoop_defines.svh */
`ifndef CARRIERLOOP_DEFINES_SVH
`define CARRIERLOOP_DEFINES_SVH

// Register bus widths
`define ADDR_WIDTH 12
`define DATA_WIDTH 32

// Value on addr[11:8] that selects the carrier loop block
`define CARRIER_BASE 4'h3

// Register offsets on addr[7:0]
`define REG_CTRL   8'h00
`define REG_LIMIT  8'h04
`define REG_SWEEP  8'h08
`define REG_LOCK   8'h0C

// Lag accumulator read-back, writes to this offset are ignored
`define REG_LAGACC 8'h10

`endif

/* rtl/carrierPkg.sv */
package carrierPkg;

    // Demodulator modes, the encoding follows the demodulator mode register
    typedef enum logic [2:0] {
        modeAm    = 3'd0,
        modePm    = 3'd1,
        modeFm    = 3'd2,
        mode2Fsk  = 3'd3,
        modeBpsk  = 3'd4,
        modeQpsk  = 3'd5,
        modeOqpsk = 3'd6,
        modeOther = 3'd7
    } demodModeT;

    typedef struct packed {
        logic        invertError;    // Negate the loop error
        logic        zeroError;      // Open the loop by forcing a zero error
        logic        sweepEnable;    // Add the sweep step while unlocked
        logic        clearAccum;     // Hold the lag accumulator at zero
        logic [4:0]  leadExp;        // Lead gain as a power of two
        logic [4:0]  lagExp;         // Lag gain as a power of two
        logic [31:0] limit;          // Magnitude bound of the lag accumulator
        logic [31:0] sweepOffsetMag; // Sweep step per error sample
        logic [15:0] lockCount;      // Counter reload value
        logic [7:0]  syncThreshold;  // Largest error magnitude still counted as good
    } loopConfigT;

    typedef struct packed {
        logic       valid;       // One cycle per accepted error sample
        logic [7:0] loopError;   // Error after invert and zero
        logic [7:0] modeError;   // Error as picked from the mode source
        logic       lockApplies; // Mode runs the lock detector
    } errorSampleT;

endpackage

/* rtl/loopRegs.sv */
`timescale 1ns/1ps
`include "carrierLoop_defines.svh"

module loopRegs (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`ADDR_WIDTH-1:0]  addr,
    input  logic [`DATA_WIDTH-1:0]  din,
    input  logic                    wr0,
    input  logic                    wr1,
    input  logic                    wr2,
    input  logic                    wr3,
    input  logic [31:0]             lagAccum,
    output logic [`DATA_WIDTH-1:0]  dout,
    output carrierPkg::loopConfigT  loopConfig
);

    logic                   blockSel;
    logic [7:0]             regOffset;
    logic [3:0]             byteWe;
    logic [`DATA_WIDTH-1:0] ctrlReg;
    logic [`DATA_WIDTH-1:0] limitReg;
    logic [`DATA_WIDTH-1:0] sweepReg;
    logic [`DATA_WIDTH-1:0] lockReg;

    // Replaces the bytes of a register whose strobes are high
    function automatic logic [`DATA_WIDTH-1:0] mergeBytes(
        input logic [`DATA_WIDTH-1:0] oldValue,
        input logic [`DATA_WIDTH-1:0] newValue,
        input logic [3:0]             we
    );
        logic [`DATA_WIDTH-1:0] result;
        result = oldValue;
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                result[i*8 +: 8] = newValue[i*8 +: 8];
            end
        end
        return result;
    endfunction

    assign blockSel  = (addr[11:8] == `CARRIER_BASE);
    assign regOffset = addr[7:0];
    assign byteWe    = {wr3, wr2, wr1, wr0};

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlReg  <= '0;
            limitReg <= '0;
            sweepReg <= '0;
            lockReg  <= '0;
        end else if (blockSel) begin
            case (regOffset)
                `REG_CTRL:  ctrlReg  <= mergeBytes(ctrlReg, din, byteWe);
                `REG_LIMIT: limitReg <= mergeBytes(limitReg, din, byteWe);
                `REG_SWEEP: sweepReg <= mergeBytes(sweepReg, din, byteWe);
                `REG_LOCK:  lockReg  <= mergeBytes(lockReg, din, byteWe);
                default:    ;                          // REG_LAGACC is read-only
            endcase
        end
    end

    always_comb begin
        dout = '0;                                     // Unused offsets read zero
        if (blockSel) begin
            case (regOffset)
                `REG_CTRL:   dout = ctrlReg;
                `REG_LIMIT:  dout = limitReg;
                `REG_SWEEP:  dout = sweepReg;
                `REG_LOCK:   dout = lockReg;
                `REG_LAGACC: dout = lagAccum;
                default:     dout = '0;
            endcase
        end
    end

    always_comb begin
        loopConfig.invertError    = ctrlReg[0];
        loopConfig.zeroError      = ctrlReg[1];
        loopConfig.sweepEnable    = ctrlReg[2];
        loopConfig.clearAccum     = ctrlReg[3];
        loopConfig.leadExp        = ctrlReg[12:8];
        loopConfig.lagExp         = ctrlReg[20:16];
        loopConfig.limit          = limitReg;
        loopConfig.sweepOffsetMag = sweepReg;
        loopConfig.lockCount      = lockReg[15:0];
        loopConfig.syncThreshold  = lockReg[23:16];
    end

    // A write with an unknown address or strobe would corrupt the loop settings
    assert property (@(posedge clk) disable iff (reset)
        !$isunknown(byteWe) && ((byteWe != 4'b0000) -> !$isunknown(addr)));

endmodule

/* rtl/errorSelect.sv */
`timescale 1ns/1ps

module errorSelect (
    input  logic                    clk,
    input  logic                    reset,
    input  carrierPkg::demodModeT   demodMode,
    input  logic [7:0]              phase,
    input  logic [7:0]              freq,
    input  logic [7:0]              offsetError,
    input  logic                    offsetErrorEn,
    input  logic                    ddcSync,
    input  logic                    resampSync,
    input  logic                    invertError,
    input  logic                    zeroError,
    output carrierPkg::errorSampleT sample
);

    logic [7:0] modeError;
    logic       modeErrorEn;
    logic       sync;
    logic       lockApplies;
    logic [7:0] qpskPhase;
    logic [7:0] adjError;
    logic       strobe;

    assign qpskPhase = phase - 8'h20;                  // Centres the QPSK phase on zero

    always_comb begin
        sync        = ddcSync;
        modeError   = 8'h00;
        modeErrorEn = 1'b1;
        lockApplies = 1'b1;
        case (demodMode)
            carrierPkg::modeAm: begin
                lockApplies = 1'b0;
            end
            carrierPkg::modePm: begin
                modeError = phase;
            end
            carrierPkg::modeFm: begin
                modeError   = freq;
                lockApplies = 1'b0;
            end
            carrierPkg::mode2Fsk: begin
                sync        = resampSync;
                modeError   = offsetError;
                modeErrorEn = offsetErrorEn;
                lockApplies = 1'b0;
            end
            carrierPkg::modeBpsk: begin
                modeError = {phase[6:0], 1'b0};        // Phase doubled for BPSK
            end
            carrierPkg::modeQpsk, carrierPkg::modeOqpsk: begin
                modeError = {qpskPhase[5:0], 2'b00};   // Phase times four for QPSK
            end
            default: begin
                sync = 1'b1;                           // Free-running with a zero error
            end
        endcase
    end

    assign strobe = sync & modeErrorEn;

    always_comb begin
        if (zeroError) begin
            adjError = 8'h00;
        end else if (invertError) begin
            adjError = ~modeError + 8'd1;
        end else begin
            adjError = modeError;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sample <= '0;
        end else begin
            sample.valid <= strobe;
            if (strobe) begin
                sample.loopError   <= adjError;
                sample.modeError   <= modeError;
                sample.lockApplies <= lockApplies;
            end
        end
    end

    // An unknown mode or strobe would leak an undefined sample into the filter
    assert property (@(posedge clk) disable iff (reset)
        !$isunknown({demodMode, ddcSync, resampSync, offsetErrorEn}));

endmodule

/* rtl/loopFilter.sv */
`timescale 1ns/1ps

module loopFilter (
    input  logic                    clk,
    input  logic                    reset,
    input  carrierPkg::loopConfigT  loopConfig,
    input  carrierPkg::errorSampleT sample,
    input  logic                    carrierLock,
    output logic [31:0]             lagAccum,
    output logic [31:0]             carrierFreqOffset,
    output logic                    carrierFreqEn
);

    logic signed [31:0] errorWide;
    logic signed [31:0] leadError;
    logic signed [31:0] lagError;
    logic signed [33:0] sweepTerm;
    logic signed [33:0] lagSum;
    logic signed [33:0] upperLimit;
    logic signed [33:0] lowerLimit;
    logic signed [33:0] lagWide;
    logic        [31:0] lagClamped;
    logic        [31:0] lagNext;

    assign errorWide = {{24{sample.loopError[7]}}, sample.loopError};
    assign leadError = errorWide <<< loopConfig.leadExp;   // Proportional path
    assign lagError  = errorWide <<< loopConfig.lagExp;    // Integral path

    // The sweep only runs while searching for the carrier
    assign sweepTerm = (loopConfig.sweepEnable && !carrierLock) ?
        {{2{loopConfig.sweepOffsetMag[31]}}, loopConfig.sweepOffsetMag} : '0;

    // Two guard bits keep the sum exact before the clamp
    assign lagSum = {{2{lagAccum[31]}}, lagAccum} + {{2{lagError[31]}}, lagError}
        + sweepTerm;

    assign upperLimit = {2'b00, loopConfig.limit};
    assign lowerLimit = -upperLimit;

    always_comb begin
        if (lagSum > upperLimit) begin
            lagClamped = upperLimit[31:0];
        end else if (lagSum < lowerLimit) begin
            lagClamped = lowerLimit[31:0];
        end else begin
            lagClamped = lagSum[31:0];
        end
    end

    assign lagNext = loopConfig.clearAccum ? 32'h0 : lagClamped;

    always_ff @(posedge clk) begin
        if (reset) begin
            lagAccum          <= '0;
            carrierFreqOffset <= '0;
            carrierFreqEn     <= 1'b0;
        end else begin
            carrierFreqEn <= sample.valid;                 // Offset is new on this pulse
            if (sample.valid) begin
                lagAccum          <= lagNext;
                carrierFreqOffset <= lagNext + leadError;  // Lead acts on the fresh lag value
            end
        end
    end

    assign lagWide = {{2{lagAccum[31]}}, lagAccum};

    // The clamp bound is the limit in force on the updating edge
    assert property (@(posedge clk) disable iff (reset)
        $past(sample.valid) |->
            (lagWide <= $signed({2'b00, $past(loopConfig.limit)})) &&
            (lagWide >= -$signed({2'b00, $past(loopConfig.limit)})));

endmodule

/* rtl/lockDetector.sv */
`timescale 1ns/1ps

module lockDetector (
    input  logic                    clk,
    input  logic                    reset,
    input  carrierPkg::loopConfigT  loopConfig,
    input  carrierPkg::errorSampleT sample,
    output logic                    carrierLock,
    output logic [15:0]             lockCounter
);

    logic [7:0]  absError;
    logic        goodSample;
    logic [16:0] lockPlus;
    logic [16:0] lockMinus;

    // Magnitude of the raw error, -128 maps to 128 as an unsigned value
    assign absError = sample.modeError[7] ? (~sample.modeError + 8'd1) : sample.modeError;
    assign goodSample = (absError <= loopConfig.syncThreshold);

    assign lockPlus  = {1'b0, lockCounter} + 17'h00001;  // Bit 16 flags the overflow
    assign lockMinus = {1'b0, lockCounter} + 17'h1ffff;  // Bit 16 flags the underflow

    always_ff @(posedge clk) begin
        if (reset) begin
            carrierLock <= 1'b0;
            lockCounter <= '0;
        end else if (sample.valid) begin
            if (!sample.lockApplies) begin
                carrierLock <= 1'b1;                      // Mode has no lock indication
            end else if (goodSample) begin
                if (lockPlus[16]) begin
                    carrierLock <= 1'b1;
                    lockCounter <= loopConfig.lockCount;
                end else begin
                    lockCounter <= lockPlus[15:0];
                end
            end else begin
                if (lockMinus[16]) begin
                    carrierLock <= 1'b0;
                    lockCounter <= loopConfig.lockCount;
                end else begin
                    lockCounter <= lockMinus[15:0];
                end
            end
        end
    end

endmodule

/* rtl/carrierLoop.sv */
`timescale 1ns/1ps
`include "carrierLoop_defines.svh"

module carrierLoop (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ddcSync,
    input  logic                   resampSync,
    input  logic                   wr0,
    input  logic                   wr1,
    input  logic                   wr2,
    input  logic                   wr3,
    input  logic [`ADDR_WIDTH-1:0] addr,
    input  logic [`DATA_WIDTH-1:0] din,
    output logic [`DATA_WIDTH-1:0] dout,
    input  carrierPkg::demodModeT  demodMode,
    input  logic [7:0]             phase,
    input  logic [7:0]             freq,
    input  logic [7:0]             offsetError,
    input  logic                   offsetErrorEn,
    output logic [31:0]            carrierFreqOffset,
    output logic                   carrierFreqEn,
    output logic [7:0]             loopError,
    output logic                   carrierLock,
    output logic [15:0]            lockCounter
);

    carrierPkg::loopConfigT  loopConfig;
    carrierPkg::errorSampleT sample;
    logic [31:0]             lagAccum;

    loopRegs loopRegs_i (
        .clk(clk), .reset(reset),
        .addr(addr), .din(din),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .lagAccum(lagAccum), .dout(dout), .loopConfig(loopConfig)
    );

    errorSelect errorSelect_i (
        .clk(clk), .reset(reset), .demodMode(demodMode),
        .phase(phase), .freq(freq), .offsetError(offsetError),
        .offsetErrorEn(offsetErrorEn), .ddcSync(ddcSync), .resampSync(resampSync),
        .invertError(loopConfig.invertError), .zeroError(loopConfig.zeroError),
        .sample(sample)
    );

    loopFilter loopFilter_i (
        .clk(clk), .reset(reset), .loopConfig(loopConfig), .sample(sample),
        .carrierLock(carrierLock), .lagAccum(lagAccum),
        .carrierFreqOffset(carrierFreqOffset), .carrierFreqEn(carrierFreqEn)
    );

    lockDetector lockDetector_i (
        .clk(clk), .reset(reset), .loopConfig(loopConfig), .sample(sample),
        .carrierLock(carrierLock), .lockCounter(lockCounter)
    );

    assign loopError = sample.loopError;   // Registered adjusted error, one cycle after the strobe

endmodule

/* bench/carrierLoopTb.sv */
`timescale 1ns/1ps
`include "carrierLoop_defines.svh"

module carrierLoopTb;

    localparam int cycleLimit = 4000;            // About twice the cycles that the tests take

    logic                  clk;
    logic                  reset;
    logic                  ddcSync;
    logic                  resampSync;
    logic                  wr0;
    logic                  wr1;
    logic                  wr2;
    logic                  wr3;
    logic [11:0]           addr;
    logic [31:0]           din;
    logic [31:0]           dout;
    carrierPkg::demodModeT demodMode;
    logic [7:0]            phase;
    logic [7:0]            freq;
    logic [7:0]            offsetError;
    logic                  offsetErrorEn;
    logic [31:0]           carrierFreqOffset;
    logic                  carrierFreqEn;
    logic [7:0]            loopError;
    logic                  carrierLock;
    logic [15:0]           lockCounter;

    // Reference state, updated on the rising edge from the DUT inputs
    logic [31:0]             ctrlShadow;
    logic [31:0]             limitShadow;
    logic [31:0]             sweepShadow;
    logic [31:0]             lockShadow;
    carrierPkg::errorSampleT expSample;
    logic [31:0]             expLag;
    logic [31:0]             expOffset;
    logic                    expFreqEn;
    logic                    expLock;
    logic [15:0]             expCounter;
    logic                    modelReady = 1'b0;
    int                      clampHits = 0;
    int                      cycleCount = 0;

    carrierLoop carrierLoop_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] mergeLanes(input logic [31:0] oldValue,
                                               input logic [31:0] newValue,
                                               input logic [3:0] lanes);
        logic [31:0] result;
        result = oldValue;
        for (int i = 0; i < 4; i++) begin
            if (lanes[i]) result[i*8 +: 8] = newValue[i*8 +: 8];
        end
        return result;
    endfunction

    function automatic carrierPkg::loopConfigT decodeConfig(input logic [31:0] ctrl,
        input logic [31:0] lim, input logic [31:0] sweep, input logic [31:0] lock);
        carrierPkg::loopConfigT c;
        c.invertError    = ctrl[0];
        c.zeroError      = ctrl[1];
        c.sweepEnable    = ctrl[2];
        c.clearAccum     = ctrl[3];
        c.leadExp        = ctrl[12:8];
        c.lagExp         = ctrl[20:16];
        c.limit          = lim;
        c.sweepOffsetMag = sweep;
        c.lockCount      = lock[15:0];
        c.syncThreshold  = lock[23:16];
        return c;
    endfunction

    // Error source table of the demodulator modes, valid holds the strobe
    function automatic carrierPkg::errorSampleT refErrorSample(
        input carrierPkg::demodModeT mode, input logic [7:0] ph, input logic [7:0] fr,
        input logic [7:0] oe, input logic ddc, input logic rs, input logic en,
        input logic invert, input logic zero);
        carrierPkg::errorSampleT s;
        logic [7:0] centred;
        s.valid       = ddc;
        s.modeError   = 8'h00;
        s.lockApplies = 1'b1;
        centred       = ph - 8'h20;
        case (mode)
            carrierPkg::modeAm: s.lockApplies = 1'b0;
            carrierPkg::modePm: s.modeError = ph;
            carrierPkg::modeFm: begin
                s.modeError   = fr;
                s.lockApplies = 1'b0;
            end
            carrierPkg::mode2Fsk: begin
                s.modeError   = oe;
                s.valid       = rs && en;
                s.lockApplies = 1'b0;
            end
            carrierPkg::modeBpsk: s.modeError = ph << 1;
            carrierPkg::modeQpsk, carrierPkg::modeOqpsk: s.modeError = centred << 2;
            default: s.valid = 1'b1;
        endcase
        if (zero) s.loopError = 8'h00;
        else if (invert) s.loopError = 8'h00 - s.modeError;
        else s.loopError = s.modeError;
        return s;
    endfunction

    // Lag sum before the clamp, wide enough to hold any overshoot
    function automatic longint lagSumOf(input logic [31:0] lag, input logic [7:0] err,
        input carrierPkg::loopConfigT cfg, input logic lock);
        longint sum;
        sum = longint'($signed(lag)) + (longint'($signed(err)) <<< cfg.lagExp);
        if (cfg.sweepEnable && !lock) sum = sum + longint'($signed(cfg.sweepOffsetMag));
        return sum;
    endfunction

    function automatic logic [31:0] expectedRead(input logic [11:0] a);
        if (a[11:8] != `CARRIER_BASE) return 32'h0;
        case (a[7:0])
            `REG_CTRL:   return ctrlShadow;
            `REG_LIMIT:  return limitShadow;
            `REG_SWEEP:  return sweepShadow;
            `REG_LOCK:   return lockShadow;
            `REG_LAGACC: return expLag;
            default:     return 32'h0;
        endcase
    endfunction

    always @(posedge clk) begin
        carrierPkg::loopConfigT  cfg;
        carrierPkg::errorSampleT nextSample;
        longint                  sum;
        longint                  lim;
        longint                  lead;
        logic [7:0]              mag;
        if (reset) begin
            {ctrlShadow, limitShadow, sweepShadow, lockShadow} = '0;
            expSample  = '0;
            {expLag, expOffset, expFreqEn, expLock, expCounter} = '0;
            modelReady = 1'b1;
        end else begin
            cfg = decodeConfig(ctrlShadow, limitShadow, sweepShadow, lockShadow);
            nextSample = refErrorSample(demodMode, phase, freq, offsetError, ddcSync,
                resampSync, offsetErrorEn, cfg.invertError, cfg.zeroError);
            expFreqEn = expSample.valid;
            if (expSample.valid) begin
                sum = lagSumOf(expLag, expSample.loopError, cfg, expLock);
                lim = {32'h0, cfg.limit};
                if (sum > lim) begin
                    sum = lim;
                    clampHits++;
                end else if (sum < -lim) begin
                    sum = -lim;
                    clampHits++;
                end
                if (cfg.clearAccum) sum = 64'sd0;
                expLag    = sum[31:0];
                lead      = longint'($signed(expSample.loopError)) <<< cfg.leadExp;
                expOffset = expLag + lead[31:0];
                mag = expSample.modeError[7] ? 8'h00 - expSample.modeError
                                             : expSample.modeError;
                if (!expSample.lockApplies) begin
                    expLock = 1'b1;
                end else if (mag > cfg.syncThreshold) begin
                    if (expCounter == 16'h0000) begin
                        expLock    = 1'b0;
                        expCounter = cfg.lockCount;
                    end else begin
                        expCounter = expCounter - 16'd1;
                    end
                end else if (expCounter == 16'hFFFF) begin
                    expLock    = 1'b1;
                    expCounter = cfg.lockCount;
                end else begin
                    expCounter = expCounter + 16'd1;
                end
            end
            expSample.valid = nextSample.valid;
            if (nextSample.valid) expSample = nextSample;
            if (addr[11:8] == `CARRIER_BASE) begin
                case (addr[7:0])
                    `REG_CTRL:  ctrlShadow  = mergeLanes(ctrlShadow, din, {wr3, wr2, wr1, wr0});
                    `REG_LIMIT: limitShadow = mergeLanes(limitShadow, din, {wr3, wr2, wr1, wr0});
                    `REG_SWEEP: sweepShadow = mergeLanes(sweepShadow, din, {wr3, wr2, wr1, wr0});
                    `REG_LOCK:  lockShadow  = mergeLanes(lockShadow, din, {wr3, wr2, wr1, wr0});
                    default: ;
                endcase
            end
        end
    end

    // Registered outputs are stable on the falling edge
    always @(negedge clk) begin
        if (modelReady) begin
            checkValue("loopError", 32'(expSample.loopError), 32'(loopError));
            checkValue("carrierFreqEn", 32'(expFreqEn), 32'(carrierFreqEn));
            checkValue("carrierFreqOffset", expOffset, carrierFreqOffset);
            checkValue("carrierLock", 32'(expLock), 32'(carrierLock));
            checkValue("lockCounter", 32'(expCounter), 32'(lockCounter));
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Error: the run did not finish within %0d cycles", cycleLimit);
            $display("TB FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic applyReset();
        reset = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic writeReg(input logic [11:0] a, input logic [31:0] d, input logic [3:0] lanes);
        addr = a;
        din  = d;
        {wr3, wr2, wr1, wr0} = lanes;
        @(negedge clk);
        {wr3, wr2, wr1, wr0} = 4'b0000;
    endtask

    task automatic readCheck(input logic [11:0] a, input logic [31:0] expected);
        addr = a;
        #1;                                      // Let the combinational read settle
        checkValue("dout", expected, dout);
        @(negedge clk);
    endtask

    task automatic sendSample(input logic [7:0] ph, input logic [7:0] fr, input logic [7:0] oe,
                              input logic ddc, input logic rs, input logic en);
        phase         = ph;
        freq          = fr;
        offsetError   = oe;
        ddcSync       = ddc;
        resampSync    = rs;
        offsetErrorEn = en;
        @(negedge clk);
        {ddcSync, resampSync, offsetErrorEn} = 3'b000;
    endtask

    task automatic testRegisters();
        logic [7:0]  offsets [0:5];
        logic [11:0] a;
        offsets = '{`REG_CTRL, `REG_LIMIT, `REG_SWEEP, `REG_LOCK, `REG_LAGACC, 8'h14};
        repeat (24) begin
            a[7:0]  = offsets[$urandom_range(0, 5)];
            a[11:8] = ($urandom_range(0, 3) == 0) ? `CARRIER_BASE ^ 4'($urandom_range(1, 15))
                                                  : `CARRIER_BASE;
            writeReg(a, $urandom, 4'($urandom));   // Random mix of byte strobes
            readCheck(a, expectedRead(a));
        end
        for (int i = 0; i < 6; i++) begin
            readCheck({`CARRIER_BASE, offsets[i]}, expectedRead({`CARRIER_BASE, offsets[i]}));
            readCheck({`CARRIER_BASE ^ 4'h8, offsets[i]}, 32'h0);
        end
    endtask

    task automatic testSweep();
        int sweepExpected;
        demodMode = carrierPkg::modeBpsk;
        writeReg({`CARRIER_BASE, `REG_LIMIT}, 32'd1000, 4'hF);
        writeReg({`CARRIER_BASE, `REG_SWEEP}, 32'd150, 4'hF);
        writeReg({`CARRIER_BASE, `REG_CTRL}, 32'h0000_0006, 4'hF);    // Sweep on, error zeroed
        for (int k = 1; k <= 10; k++) begin
            sendSample(8'h00, 8'h00, 8'h00, 1'b1, 1'b0, 1'b0);
            idle(1);
            sweepExpected = (150 * k > 1000) ? 1000 : 150 * k;
            readCheck({`CARRIER_BASE, `REG_LAGACC}, 32'(sweepExpected));
        end
        writeReg({`CARRIER_BASE, `REG_CTRL}, 32'h0000_000E, 4'b0001);
        sendSample(8'h00, 8'h00, 8'h00, 1'b1, 1'b0, 1'b0);
        idle(1);
        readCheck({`CARRIER_BASE, `REG_LAGACC}, 32'h0);
        writeReg({`CARRIER_BASE, `REG_CTRL}, 32'h0, 4'b0001);
    endtask

    task automatic testLock();
        int         riseStrobes;
        int         dropStrobes;
        logic [7:0] ph;
        riseStrobes = 'h10000 - 'hFFF0;          // Counts up from the reload to the overflow
        dropStrobes = 4 + 1;                     // Counts down from the new reload past zero
        demodMode = carrierPkg::modeBpsk;
        writeReg({`CARRIER_BASE, `REG_LOCK}, 32'h0010_FFF0, 4'hF);
        sendSample(8'h20, 8'h00, 8'h00, 1'b1, 1'b0, 1'b0);    // Underflow from zero
        idle(1);
        checkValue("lockCounter", 32'h0000_FFF0, 32'(lockCounter));
        for (int i = 1; i <= riseStrobes; i++) begin
            if (i == riseStrobes) writeReg({`CARRIER_BASE, `REG_LOCK}, 32'h0000_0004, 4'b0011);
            ph = 8'($urandom_range(0, 7));
            if ($urandom_range(0, 1) == 1) ph = 8'h00 - ph;
            sendSample(ph, 8'h00, 8'h00, 1'b1, 1'b0, 1'b0);
            idle(1);
            checkValue("carrierLock", 32'(i == riseStrobes), 32'(carrierLock));
        end
        for (int i = 1; i <= dropStrobes; i++) begin
            sendSample(8'($urandom_range(8'h10, 8'h3F)), 8'h00, 8'h00, 1'b1, 1'b0, 1'b0);
            idle(1);
            checkValue("carrierLock", 32'(i < dropStrobes), 32'(carrierLock));
        end
        demodMode = carrierPkg::modeFm;
        sendSample(8'h00, 8'($urandom), 8'h00, 1'b1, 1'b0, 1'b0);
        idle(1);
        checkValue("carrierLock", 32'h1, 32'(carrierLock));
    endtask

    task automatic testErrorSource();
        logic ddc;
        writeReg({`CARRIER_BASE, `REG_LIMIT}, 32'h0100_0000, 4'hF);
        writeReg({`CARRIER_BASE, `REG_SWEEP}, 32'h0, 4'hF);
        for (int m = 0; m < 8; m++) begin
            demodMode = carrierPkg::demodModeT'(3'(m));
            for (int combo = 0; combo < 4; combo++) begin
                writeReg({`CARRIER_BASE, `REG_CTRL}, {11'h0, 5'($urandom_range(0, 20)), 3'h0,
                         5'($urandom_range(0, 20)), 6'h0, 2'(combo)}, 4'hF);
                repeat (10) begin
                    ddc = (demodMode == carrierPkg::mode2Fsk) ? 1'($urandom) : 1'b1;
                    sendSample(8'($urandom), 8'($urandom), 8'($urandom), ddc,
                               1'($urandom), 1'($urandom));
                    idle(int'($urandom_range(0, 2)));
                end
            end
        end
    endtask

    task automatic testFilter();
        demodMode = carrierPkg::modePm;
        writeReg({`CARRIER_BASE, `REG_LIMIT}, 32'd3000, 4'hF);
        repeat (10) begin
            writeReg({`CARRIER_BASE, `REG_CTRL}, {11'h0, 5'($urandom_range(0, 6)), 3'h0,
                     5'($urandom_range(0, 8)), 6'h0, 1'b0, 1'($urandom)}, 4'hF);
            repeat (40) begin
                sendSample(8'($urandom), 8'h00, 8'h00, 1'b1, 1'b0, 1'b0);
                idle(int'($urandom_range(0, 2)));    // Zero gap keeps two samples in flight
            end
        end
    endtask

    initial begin
        int clampBase;
        reset = 1'b1;
        {ddcSync, resampSync, offsetErrorEn} = 3'b000;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        addr        = '0;
        din         = '0;
        demodMode   = carrierPkg::modeBpsk;
        phase       = 8'h00;
        freq        = 8'h00;
        offsetError = 8'h00;
        void'($urandom(32'he354_6252));
        applyReset();
        testRegisters();
        testSweep();
        applyReset();
        testLock();
        testErrorSource();
        clampBase = clampHits;
        testFilter();
        idle(4);                                 // Drain the last samples through the compare
        if (clampHits == clampBase) begin
            $display("Error: the filter test never drove the lag accumulator into the clamp");
            $display("TB FAILED");
            $fatal(1, "clamp not exercised");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

/* src.f */
+incdir+rtl
rtl/carrierPkg.sv
rtl/loopRegs.sv
rtl/errorSelect.sv
rtl/loopFilter.sv
rtl/lockDetector.sv
rtl/carrierLoop.sv
bench/carrierLoopTb.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module carrierLoopTb -f src.f -o carrierLoopSim \
    && ./obj_dir/carrierLoopSim \
    || { echo "carrier loop simulation returned a failing status"; exit 1; }
